/* enc_geom_pkg.sv */
// ********************
// picture geometry defaults for the encoder controller
// the top level takes its MB index widths from here
// ********************
package enc_geom_pkg;

	// MB column index width
	localparam int MB_X_W_DEF = 8;

	// MB row index width
	localparam int MB_Y_W_DEF = 8;

endpackage

/* enc_ctrl_pkg.sv */
// ********************
// encoder pipeline control definitions
// state encoding plus bit positions of the done flags and stage starts
// ********************
package enc_ctrl_pkg;

	// ********************
	// pipeline states
	typedef enum logic [3:0] {
		IDLE  = 4'd0,
		INIT  = 4'd1,
		LOAD  = 4'd2,   // fill, first MB load only
		I_S0  = 4'd3,
		I_S1  = 4'd4,   // intra steady
		I_S2  = 4'd5,
		I_S3  = 4'd6,
		P_S0  = 4'd7,
		P_S1  = 4'd8,
		P_S2  = 4'd9,
		P_S3  = 4'd10,  // inter steady
		P_S4  = 4'd11,
		P_S5  = 4'd12,
		P_S6  = 4'd13,
		P_S7  = 4'd14,
		STORE = 4'd15   // wait for bitstream buffer
	} pipe_state_e;

	// ********************
	// done sources
	localparam int DONE_N = 10;

	typedef enum int {
		DN_LOAD     = 0,
		DN_F_LUMA   = 1,  // luma reference fetch
		DN_F_CHROMA = 2,  // chroma search window fetch
		DN_F_DB     = 3,  // db reference load / recon store
		DN_INTRA    = 4,
		DN_IME      = 5,
		DN_FME      = 6,
		DN_MC       = 7,
		DN_EC       = 8,
		DN_DB       = 9
	} done_idx_e;

	// ********************
	// processing stages
	localparam int STAGE_N = 7;

	typedef enum int {
		ST_LOAD  = 0,
		ST_INTRA = 1,
		ST_IME   = 2,
		ST_FME   = 3,
		ST_MC    = 4,
		ST_EC    = 5,
		ST_DB    = 6
	} stage_idx_e;

endpackage

/* done_flag_bank.sv */
// ********************
// sticky done flags for the MB pipeline
// a rising edge on a done input sets its flag, the MB step clears all flags
// ********************
`timescale 1ns/1ns

module done_flag_bank (
	input  logic                             clk,
	input  logic                             rst_n,
	input  logic [enc_ctrl_pkg::DONE_N-1:0]  done_i,
	input  logic                             mb_done_i,
	output logic [enc_ctrl_pkg::DONE_N-1:0]  flags_o
);

	logic [enc_ctrl_pkg::DONE_N-1:0] done_q;  // previous done level
	logic [enc_ctrl_pkg::DONE_N-1:0] done_rise;
	logic [enc_ctrl_pkg::DONE_N-1:0] flags_kept;

	assign done_rise = done_i & ~done_q;

	// all flags drop together at the end of an MB step
	assign flags_kept = mb_done_i ? '0 : flags_o;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			done_q  <= '0;
			flags_o <= '0;
		end else begin
			done_q  <= done_i;
			flags_o <= flags_kept | done_rise;  // set wins over clear
		end
	end

endmodule

/* pipe_fsm.sv */
// ********************
// frame level pipeline FSM of the encoder
// fill, steady and drain states for intra and inter frames
// gives the MB step and the frame start, frame done and system done status
// ********************
`timescale 1ns/1ns

module pipe_fsm (
	input  logic                             clk,
	input  logic                             rst_n,
	input  logic                             sys_start_i,
	input  logic                             sys_intra_i,
	input  logic                             bs_empty_i,
	input  logic [enc_ctrl_pkg::DONE_N-1:0]  flags_i,
	input  logic                             last_mb_i,
	output enc_ctrl_pkg::pipe_state_e        state_o,
	output logic                             init_o,
	output logic                             mb_done_o,
	output logic                             frame_start_o,
	output logic                             frame_done_o,
	output logic                             sys_done_o
);

	localparam int N = enc_ctrl_pkg::DONE_N;
	localparam logic [N-1:0] ONE = 1;

	// single flag masks
	localparam logic [N-1:0] M_LD  = ONE << enc_ctrl_pkg::DN_LOAD;
	localparam logic [N-1:0] M_FL  = ONE << enc_ctrl_pkg::DN_F_LUMA;
	localparam logic [N-1:0] M_FC  = ONE << enc_ctrl_pkg::DN_F_CHROMA;
	localparam logic [N-1:0] M_FD  = ONE << enc_ctrl_pkg::DN_F_DB;
	localparam logic [N-1:0] M_IN  = ONE << enc_ctrl_pkg::DN_INTRA;
	localparam logic [N-1:0] M_IME = ONE << enc_ctrl_pkg::DN_IME;
	localparam logic [N-1:0] M_FME = ONE << enc_ctrl_pkg::DN_FME;
	localparam logic [N-1:0] M_MC  = ONE << enc_ctrl_pkg::DN_MC;
	localparam logic [N-1:0] M_EC  = ONE << enc_ctrl_pkg::DN_EC;
	localparam logic [N-1:0] M_DB  = ONE << enc_ctrl_pkg::DN_DB;

	// ec, db and the db fetch close every MB
	localparam logic [N-1:0] M_TAIL = M_EC | M_DB | M_FD;
	localparam logic [N-1:0] M_P0   = M_LD | M_IME | M_FL | M_FC;

	enc_ctrl_pkg::pipe_state_e state_q, state_r, state_d, state_adv;
	logic [N-1:0] req;   // flags the current step waits on
	logic         step_st;

	// ********************
	// required flags and the state after a step
	always_comb begin
		req       = '0;
		step_st   = 1'b1;
		state_adv = state_q;
		case (state_q)
			enc_ctrl_pkg::IDLE: begin
				step_st   = 1'b0;
				state_adv = sys_start_i ? enc_ctrl_pkg::INIT : enc_ctrl_pkg::IDLE;
			end
			enc_ctrl_pkg::INIT: begin
				step_st   = 1'b0;
				state_adv = enc_ctrl_pkg::LOAD;
			end
			enc_ctrl_pkg::LOAD: begin
				req       = sys_intra_i ? M_LD : (M_LD | M_FL);
				state_adv = sys_intra_i ? enc_ctrl_pkg::I_S0 : enc_ctrl_pkg::P_S0;
			end
			enc_ctrl_pkg::I_S0: begin
				req       = M_LD | M_IN;
				state_adv = enc_ctrl_pkg::I_S1;
			end
			enc_ctrl_pkg::I_S1: begin
				req       = M_LD | M_IN | M_TAIL;
				state_adv = last_mb_i ? enc_ctrl_pkg::I_S2 : enc_ctrl_pkg::I_S1;
			end
			enc_ctrl_pkg::I_S2: begin
				req       = M_IN | M_TAIL;
				state_adv = enc_ctrl_pkg::I_S3;
			end
			enc_ctrl_pkg::P_S0: begin
				req       = M_P0;
				state_adv = enc_ctrl_pkg::P_S1;
			end
			enc_ctrl_pkg::P_S1: begin
				req       = M_P0 | M_FME;
				state_adv = enc_ctrl_pkg::P_S2;
			end
			enc_ctrl_pkg::P_S2: begin
				req       = M_P0 | M_FME | M_MC;
				state_adv = enc_ctrl_pkg::P_S3;
			end
			enc_ctrl_pkg::P_S3: begin
				req       = M_P0 | M_FME | M_MC | M_TAIL;
				state_adv = last_mb_i ? enc_ctrl_pkg::P_S4 : enc_ctrl_pkg::P_S3;
			end
			enc_ctrl_pkg::P_S4: begin  // load done
				req       = M_IME | M_FME | M_MC | M_TAIL;
				state_adv = enc_ctrl_pkg::P_S5;
			end
			enc_ctrl_pkg::P_S5: begin  // ime done
				req       = M_FME | M_MC | M_TAIL;
				state_adv = enc_ctrl_pkg::P_S6;
			end
			enc_ctrl_pkg::P_S6: begin  // fme done
				req       = M_MC | M_TAIL;
				state_adv = enc_ctrl_pkg::P_S7;
			end
			enc_ctrl_pkg::I_S3, enc_ctrl_pkg::P_S7: begin
				req       = M_TAIL;
				state_adv = enc_ctrl_pkg::STORE;
			end
			enc_ctrl_pkg::STORE: begin
				step_st   = 1'b0;
				state_adv = bs_empty_i ? enc_ctrl_pkg::IDLE : enc_ctrl_pkg::STORE;
			end
			default: begin
				step_st   = 1'b0;
				state_adv = enc_ctrl_pkg::IDLE;
			end
		endcase
	end

	assign mb_done_o = step_st & (&(flags_i | ~req));
	assign state_d   = (step_st && !mb_done_o) ? state_q : state_adv;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state_q <= enc_ctrl_pkg::IDLE;
			state_r <= enc_ctrl_pkg::IDLE;
		end else begin
			state_q <= state_d;
			state_r <= state_q;
		end
	end

	// ********************
	// frame status
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			frame_start_o <= 1'b0;
			frame_done_o  <= 1'b0;
			sys_done_o    <= 1'b1;
		end else begin
			frame_start_o <= (state_r == enc_ctrl_pkg::INIT);  // reference fetch kick
			frame_done_o  <= (state_d == enc_ctrl_pkg::STORE) &&
			                 (state_q != enc_ctrl_pkg::STORE);
			if (sys_start_i)
				sys_done_o <= 1'b0;
			else if (state_q == enc_ctrl_pkg::IDLE && state_r != enc_ctrl_pkg::IDLE)
				sys_done_o <= 1'b1;  // back in idle
		end
	end

	assign state_o = state_q;
	assign init_o  = (state_q == enc_ctrl_pkg::INIT);

endmodule

/* stage_start_gen.sv */
// ********************
// stage start pulses of the MB pipeline
// one cycle start for each stage working in the new state, one cycle after the step
// ********************
`timescale 1ns/1ns

module stage_start_gen (
	input  logic                              clk,
	input  logic                              rst_n,
	input  enc_ctrl_pkg::pipe_state_e         state_i,
	input  logic                              mb_done_i,
	input  logic                              frame_start_i,
	output logic [enc_ctrl_pkg::STAGE_N-1:0]  start_o
);

	localparam int N = enc_ctrl_pkg::STAGE_N;
	localparam logic [N-1:0] ONE = 1;

	localparam logic [N-1:0] S_LD  = ONE << enc_ctrl_pkg::ST_LOAD;
	localparam logic [N-1:0] S_IN  = ONE << enc_ctrl_pkg::ST_INTRA;
	localparam logic [N-1:0] S_IME = ONE << enc_ctrl_pkg::ST_IME;
	localparam logic [N-1:0] S_FME = ONE << enc_ctrl_pkg::ST_FME;
	localparam logic [N-1:0] S_MC  = ONE << enc_ctrl_pkg::ST_MC;
	localparam logic [N-1:0] S_TL  = (ONE << enc_ctrl_pkg::ST_EC) | (ONE << enc_ctrl_pkg::ST_DB);

	logic [N-1:0] working;
	logic         mb_done_r;

	// working stages per state, drain drops one stage per step
	always_comb begin
		case (state_i)
			enc_ctrl_pkg::LOAD: working = S_LD;
			enc_ctrl_pkg::I_S0: working = S_LD | S_IN;
			enc_ctrl_pkg::I_S1: working = S_LD | S_IN | S_TL;
			enc_ctrl_pkg::I_S2: working = S_IN | S_TL;
			enc_ctrl_pkg::I_S3: working = S_TL;
			enc_ctrl_pkg::P_S0: working = S_LD | S_IME;
			enc_ctrl_pkg::P_S1: working = S_LD | S_IME | S_FME;
			enc_ctrl_pkg::P_S2: working = S_LD | S_IME | S_FME | S_MC;
			enc_ctrl_pkg::P_S3: working = S_LD | S_IME | S_FME | S_MC | S_TL;
			enc_ctrl_pkg::P_S4: working = S_IME | S_FME | S_MC | S_TL;
			enc_ctrl_pkg::P_S5: working = S_FME | S_MC | S_TL;
			enc_ctrl_pkg::P_S6: working = S_MC | S_TL;
			enc_ctrl_pkg::P_S7: working = S_TL;
			default:            working = '0;  // idle, init, store
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mb_done_r <= 1'b0;
			start_o   <= '0;
		end else begin
			mb_done_r <= mb_done_i;  // state has moved by now
			start_o   <= mb_done_r ? working : '0;
			if (frame_start_i)
				start_o[enc_ctrl_pkg::ST_LOAD] <= working[enc_ctrl_pkg::ST_LOAD];  // first MB
		end
	end

endmodule

/* mb_index_pipe.sv */
// ********************
// MB index pipeline
// raster counter for load, each later stage copies its upstream index on a step
// ********************
`timescale 1ns/1ns

module mb_index_pipe #(
	parameter int X_W = 8,
	parameter int Y_W = 8
) (
	input  logic                             clk,
	input  logic                             rst_n,
	input  logic                             sys_intra_i,
	input  logic [X_W-1:0]                   x_total_i,
	input  logic [Y_W-1:0]                   y_total_i,
	input  logic [enc_ctrl_pkg::DONE_N-1:0]  flags_i,
	input  logic                             mb_done_i,
	input  logic                             frame_init_i,
	output logic [X_W-1:0]                   mb_x_load_o,
	output logic [Y_W-1:0]                   mb_y_load_o,
	output logic [X_W-1:0]                   mb_x_intra_o,
	output logic [Y_W-1:0]                   mb_y_intra_o,
	output logic [X_W-1:0]                   mb_x_ime_o,
	output logic [Y_W-1:0]                   mb_y_ime_o,
	output logic [X_W-1:0]                   mb_x_fme_o,
	output logic [Y_W-1:0]                   mb_y_fme_o,
	output logic [X_W-1:0]                   mb_x_mc_o,
	output logic [Y_W-1:0]                   mb_y_mc_o,
	output logic [X_W-1:0]                   mb_x_ec_o,
	output logic [Y_W-1:0]                   mb_y_ec_o,
	output logic [X_W-1:0]                   mb_x_db_o,
	output logic [Y_W-1:0]                   mb_y_db_o,
	output logic                             last_mb_o
);

	localparam int S = enc_ctrl_pkg::STAGE_N;

	logic [S-1:0][X_W-1:0] x_q, x_src;
	logic [S-1:0][Y_W-1:0] y_q, y_src;
	logic [S-1:0]          step;  // stage finished its MB in this step

	assign step[enc_ctrl_pkg::ST_LOAD]  = mb_done_i & flags_i[enc_ctrl_pkg::DN_LOAD];
	assign step[enc_ctrl_pkg::ST_INTRA] = mb_done_i & flags_i[enc_ctrl_pkg::DN_INTRA];
	assign step[enc_ctrl_pkg::ST_IME]   = mb_done_i & flags_i[enc_ctrl_pkg::DN_IME];
	assign step[enc_ctrl_pkg::ST_FME]   = mb_done_i & flags_i[enc_ctrl_pkg::DN_FME];
	assign step[enc_ctrl_pkg::ST_MC]    = mb_done_i & flags_i[enc_ctrl_pkg::DN_MC];
	assign step[enc_ctrl_pkg::ST_EC]    = mb_done_i & flags_i[enc_ctrl_pkg::DN_EC];
	assign step[enc_ctrl_pkg::ST_DB]    = mb_done_i & flags_i[enc_ctrl_pkg::DN_DB];

	always_comb begin
		x_src = x_q;
		y_src = y_q;
		// raster order, x fastest
		if (x_q[enc_ctrl_pkg::ST_LOAD] == x_total_i) begin
			x_src[enc_ctrl_pkg::ST_LOAD] = '0;
			if (y_q[enc_ctrl_pkg::ST_LOAD] == y_total_i)
				y_src[enc_ctrl_pkg::ST_LOAD] = '0;
			else
				y_src[enc_ctrl_pkg::ST_LOAD] = y_q[enc_ctrl_pkg::ST_LOAD] + 1'b1;
		end else begin
			x_src[enc_ctrl_pkg::ST_LOAD] = x_q[enc_ctrl_pkg::ST_LOAD] + 1'b1;
		end
		x_src[enc_ctrl_pkg::ST_INTRA] = x_q[enc_ctrl_pkg::ST_LOAD];
		y_src[enc_ctrl_pkg::ST_INTRA] = y_q[enc_ctrl_pkg::ST_LOAD];
		x_src[enc_ctrl_pkg::ST_IME]   = x_q[enc_ctrl_pkg::ST_LOAD];
		y_src[enc_ctrl_pkg::ST_IME]   = y_q[enc_ctrl_pkg::ST_LOAD];
		x_src[enc_ctrl_pkg::ST_FME]   = x_q[enc_ctrl_pkg::ST_IME];
		y_src[enc_ctrl_pkg::ST_FME]   = y_q[enc_ctrl_pkg::ST_IME];
		x_src[enc_ctrl_pkg::ST_MC]    = x_q[enc_ctrl_pkg::ST_FME];
		y_src[enc_ctrl_pkg::ST_MC]    = y_q[enc_ctrl_pkg::ST_FME];
		// ec and db follow intra or mc by frame type
		x_src[enc_ctrl_pkg::ST_EC] = sys_intra_i ? x_q[enc_ctrl_pkg::ST_INTRA]
		                                         : x_q[enc_ctrl_pkg::ST_MC];
		y_src[enc_ctrl_pkg::ST_EC] = sys_intra_i ? y_q[enc_ctrl_pkg::ST_INTRA]
		                                         : y_q[enc_ctrl_pkg::ST_MC];
		x_src[enc_ctrl_pkg::ST_DB] = x_src[enc_ctrl_pkg::ST_EC];
		y_src[enc_ctrl_pkg::ST_DB] = y_src[enc_ctrl_pkg::ST_EC];
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			x_q <= '0;
			y_q <= '0;
		end else if (frame_init_i) begin
			x_q <= '0;
			y_q <= '0;
		end else begin
			for (int s = 0; s < S; s++) begin
				if (step[s]) begin
					x_q[s] <= x_src[s];
					y_q[s] <= y_src[s];
				end
			end
		end
	end

	assign last_mb_o = (x_q[enc_ctrl_pkg::ST_LOAD] == x_total_i) &&
	                   (y_q[enc_ctrl_pkg::ST_LOAD] == y_total_i);

	assign mb_x_load_o  = x_q[enc_ctrl_pkg::ST_LOAD];
	assign mb_y_load_o  = y_q[enc_ctrl_pkg::ST_LOAD];
	assign mb_x_intra_o = x_q[enc_ctrl_pkg::ST_INTRA];
	assign mb_y_intra_o = y_q[enc_ctrl_pkg::ST_INTRA];
	assign mb_x_ime_o   = x_q[enc_ctrl_pkg::ST_IME];
	assign mb_y_ime_o   = y_q[enc_ctrl_pkg::ST_IME];
	assign mb_x_fme_o   = x_q[enc_ctrl_pkg::ST_FME];
	assign mb_y_fme_o   = y_q[enc_ctrl_pkg::ST_FME];
	assign mb_x_mc_o    = x_q[enc_ctrl_pkg::ST_MC];
	assign mb_y_mc_o    = y_q[enc_ctrl_pkg::ST_MC];
	assign mb_x_ec_o    = x_q[enc_ctrl_pkg::ST_EC];
	assign mb_y_ec_o    = y_q[enc_ctrl_pkg::ST_EC];
	assign mb_x_db_o    = x_q[enc_ctrl_pkg::ST_DB];
	assign mb_y_db_o    = y_q[enc_ctrl_pkg::ST_DB];

endmodule

/* enc_top_ctrl.sv */
// ********************
// top controller of the MB encoder
// sequences load, intra, ime, fme, mc, ec and db over one frame per sys_start_i
// ********************
`timescale 1ns/1ns

module enc_top_ctrl #(
	parameter int X_W = enc_geom_pkg::MB_X_W_DEF,
	parameter int Y_W = enc_geom_pkg::MB_Y_W_DEF
) (
	input  logic           clk,
	input  logic           rst_n,
	// system
	input  logic           sys_start_i,
	input  logic           sys_intra_i,
	input  logic [X_W-1:0] sys_x_total_i,  // last MB column
	input  logic [Y_W-1:0] sys_y_total_i,  // last MB row
	output logic           sys_done_o,
	output logic           frame_start_o,
	output logic           frame_done_o,
	input  logic           bs_empty_i,
	// stage done pulses
	input  logic           load_done_i,
	input  logic           fetch_luma_done_i,
	input  logic           fetch_chroma_done_i,
	input  logic           fetch_db_done_i,
	input  logic           intra_done_i,
	input  logic           ime_done_i,
	input  logic           fme_done_i,
	input  logic           mc_done_i,
	input  logic           ec_done_i,
	input  logic           db_done_i,
	// stage starts
	output logic           load_start_o,
	output logic           intra_start_o,
	output logic           ime_start_o,
	output logic           fme_start_o,
	output logic           mc_start_o,
	output logic           ec_start_o,
	output logic           db_start_o,
	// MB index per stage
	output logic [X_W-1:0] mb_x_load_o,
	output logic [Y_W-1:0] mb_y_load_o,
	output logic [X_W-1:0] mb_x_intra_o,
	output logic [Y_W-1:0] mb_y_intra_o,
	output logic [X_W-1:0] mb_x_ime_o,
	output logic [Y_W-1:0] mb_y_ime_o,
	output logic [X_W-1:0] mb_x_fme_o,
	output logic [Y_W-1:0] mb_y_fme_o,
	output logic [X_W-1:0] mb_x_mc_o,
	output logic [Y_W-1:0] mb_y_mc_o,
	output logic [X_W-1:0] mb_x_ec_o,
	output logic [Y_W-1:0] mb_y_ec_o,
	output logic [X_W-1:0] mb_x_db_o,
	output logic [Y_W-1:0] mb_y_db_o
);

	logic [enc_ctrl_pkg::DONE_N-1:0]  done_vec, flags;
	logic [enc_ctrl_pkg::STAGE_N-1:0] start_vec;
	enc_ctrl_pkg::pipe_state_e        state;
	logic                             mb_done, last_mb, frame_init;

	assign done_vec[enc_ctrl_pkg::DN_LOAD]     = load_done_i;
	assign done_vec[enc_ctrl_pkg::DN_F_LUMA]   = fetch_luma_done_i;
	assign done_vec[enc_ctrl_pkg::DN_F_CHROMA] = fetch_chroma_done_i;
	assign done_vec[enc_ctrl_pkg::DN_F_DB]     = fetch_db_done_i;
	assign done_vec[enc_ctrl_pkg::DN_INTRA]    = intra_done_i;
	assign done_vec[enc_ctrl_pkg::DN_IME]      = ime_done_i;
	assign done_vec[enc_ctrl_pkg::DN_FME]      = fme_done_i;
	assign done_vec[enc_ctrl_pkg::DN_MC]       = mc_done_i;
	assign done_vec[enc_ctrl_pkg::DN_EC]       = ec_done_i;
	assign done_vec[enc_ctrl_pkg::DN_DB]       = db_done_i;

	assign load_start_o  = start_vec[enc_ctrl_pkg::ST_LOAD];
	assign intra_start_o = start_vec[enc_ctrl_pkg::ST_INTRA];
	assign ime_start_o   = start_vec[enc_ctrl_pkg::ST_IME];
	assign fme_start_o   = start_vec[enc_ctrl_pkg::ST_FME];
	assign mc_start_o    = start_vec[enc_ctrl_pkg::ST_MC];
	assign ec_start_o    = start_vec[enc_ctrl_pkg::ST_EC];
	assign db_start_o    = start_vec[enc_ctrl_pkg::ST_DB];

	done_flag_bank i_done_flag_bank (
		.clk       (clk),
		.rst_n     (rst_n),
		.done_i    (done_vec),
		.mb_done_i (mb_done),
		.flags_o   (flags)
	);

	pipe_fsm i_pipe_fsm (
		.clk           (clk),
		.rst_n         (rst_n),
		.sys_start_i   (sys_start_i),
		.sys_intra_i   (sys_intra_i),
		.bs_empty_i    (bs_empty_i),
		.flags_i       (flags),
		.last_mb_i     (last_mb),
		.state_o       (state),
		.init_o        (frame_init),
		.mb_done_o     (mb_done),
		.frame_start_o (frame_start_o),
		.frame_done_o  (frame_done_o),
		.sys_done_o    (sys_done_o)
	);

	stage_start_gen i_stage_start_gen (
		.clk           (clk),
		.rst_n         (rst_n),
		.state_i       (state),
		.mb_done_i     (mb_done),
		.frame_start_i (frame_start_o),
		.start_o       (start_vec)
	);

	mb_index_pipe #(
		.X_W (X_W),
		.Y_W (Y_W)
	) i_mb_index_pipe (
		.clk          (clk),
		.rst_n        (rst_n),
		.sys_intra_i  (sys_intra_i),
		.x_total_i    (sys_x_total_i),
		.y_total_i    (sys_y_total_i),
		.flags_i      (flags),
		.mb_done_i    (mb_done),
		.frame_init_i (frame_init),
		.mb_x_load_o  (mb_x_load_o),
		.mb_y_load_o  (mb_y_load_o),
		.mb_x_intra_o (mb_x_intra_o),
		.mb_y_intra_o (mb_y_intra_o),
		.mb_x_ime_o   (mb_x_ime_o),
		.mb_y_ime_o   (mb_y_ime_o),
		.mb_x_fme_o   (mb_x_fme_o),
		.mb_y_fme_o   (mb_y_fme_o),
		.mb_x_mc_o    (mb_x_mc_o),
		.mb_y_mc_o    (mb_y_mc_o),
		.mb_x_ec_o    (mb_x_ec_o),
		.mb_y_ec_o    (mb_y_ec_o),
		.mb_x_db_o    (mb_x_db_o),
		.mb_y_db_o    (mb_y_db_o),
		.last_mb_o    (last_mb)
	);

endmodule

/* tb_enc_top_ctrl.sv */
// ********************
// testbench for the encoder top controller
// runs a table of intra and inter frames against a stage responder model
// ********************
`timescale 1ns/1ns

module tb_enc_top_ctrl;

	localparam int X_W  = 4;
	localparam int Y_W  = 4;
	localparam int ROWS = 4;
	localparam int SN   = enc_ctrl_pkg::STAGE_N;

	// ********************
	// frame table
	string row_name  [ROWS] = '{"intra_3x2", "inter_4x2", "intra_5x1", "inter_3x3"};
	bit    row_intra [ROWS] = '{1'b1, 1'b0, 1'b1, 1'b0};
	int    row_xt    [ROWS] = '{2, 3, 4, 2};
	int    row_yt    [ROWS] = '{1, 1, 0, 2};
	int    row_bs    [ROWS] = '{5, 3, 1, 8};  // bs_empty low cycles after frame_done
	string st_name   [SN]   = '{"load", "intra", "ime", "fme", "mc", "ec", "db"};

	logic                   clk, rst_n;
	logic                   sys_start, sys_intra, bs_empty;
	logic [X_W-1:0]         x_total;
	logic [Y_W-1:0]         y_total;
	logic                   sys_done, frame_start, frame_done;
	logic [SN-1:0]          stage_done;  // responder pulses
	logic [SN-1:0]          start_v;
	logic [SN-1:0][X_W-1:0] mb_x;
	logic [SN-1:0][Y_W-1:0] mb_y;

	int    seed = 79;
	int    dly [SN];
	bit    busy [SN];
	int    start_cnt [SN];
	int    fd_cnt, cycles, limit, cur_xt;
	int    n_checks, n_errors, n_tests, n_failed;
	string cur_test;

	always #2 clk = ~clk;

	enc_top_ctrl #(
		.X_W (X_W),
		.Y_W (Y_W)
	) i_dut (
		.clk                 (clk),
		.rst_n               (rst_n),
		.sys_start_i         (sys_start),
		.sys_intra_i         (sys_intra),
		.sys_x_total_i       (x_total),
		.sys_y_total_i       (y_total),
		.sys_done_o          (sys_done),
		.frame_start_o       (frame_start),
		.frame_done_o        (frame_done),
		.bs_empty_i          (bs_empty),
		.load_done_i         (stage_done[enc_ctrl_pkg::ST_LOAD]),
		.fetch_luma_done_i   (stage_done[enc_ctrl_pkg::ST_LOAD]),  // fetches ride on load
		.fetch_chroma_done_i (stage_done[enc_ctrl_pkg::ST_LOAD]),
		.fetch_db_done_i     (stage_done[enc_ctrl_pkg::ST_DB]),
		.intra_done_i        (stage_done[enc_ctrl_pkg::ST_INTRA]),
		.ime_done_i          (stage_done[enc_ctrl_pkg::ST_IME]),
		.fme_done_i          (stage_done[enc_ctrl_pkg::ST_FME]),
		.mc_done_i           (stage_done[enc_ctrl_pkg::ST_MC]),
		.ec_done_i           (stage_done[enc_ctrl_pkg::ST_EC]),
		.db_done_i           (stage_done[enc_ctrl_pkg::ST_DB]),
		.load_start_o        (start_v[enc_ctrl_pkg::ST_LOAD]),
		.intra_start_o       (start_v[enc_ctrl_pkg::ST_INTRA]),
		.ime_start_o         (start_v[enc_ctrl_pkg::ST_IME]),
		.fme_start_o         (start_v[enc_ctrl_pkg::ST_FME]),
		.mc_start_o          (start_v[enc_ctrl_pkg::ST_MC]),
		.ec_start_o          (start_v[enc_ctrl_pkg::ST_EC]),
		.db_start_o          (start_v[enc_ctrl_pkg::ST_DB]),
		.mb_x_load_o         (mb_x[enc_ctrl_pkg::ST_LOAD]),
		.mb_y_load_o         (mb_y[enc_ctrl_pkg::ST_LOAD]),
		.mb_x_intra_o        (mb_x[enc_ctrl_pkg::ST_INTRA]),
		.mb_y_intra_o        (mb_y[enc_ctrl_pkg::ST_INTRA]),
		.mb_x_ime_o          (mb_x[enc_ctrl_pkg::ST_IME]),
		.mb_y_ime_o          (mb_y[enc_ctrl_pkg::ST_IME]),
		.mb_x_fme_o          (mb_x[enc_ctrl_pkg::ST_FME]),
		.mb_y_fme_o          (mb_y[enc_ctrl_pkg::ST_FME]),
		.mb_x_mc_o           (mb_x[enc_ctrl_pkg::ST_MC]),
		.mb_y_mc_o           (mb_y[enc_ctrl_pkg::ST_MC]),
		.mb_x_ec_o           (mb_x[enc_ctrl_pkg::ST_EC]),
		.mb_y_ec_o           (mb_y[enc_ctrl_pkg::ST_EC]),
		.mb_x_db_o           (mb_x[enc_ctrl_pkg::ST_DB]),
		.mb_y_db_o           (mb_y[enc_ctrl_pkg::ST_DB])
	);

	// ********************
	// compare tasks
	task automatic check_bit(input string name, input logic exp, input logic act);
		n_checks++;
		if (act !== exp) begin
			n_errors++;
			$display("MISMATCH %s: expected %b, actual %b", name, exp, act);
		end
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		n_checks++;
		if (act != exp) begin
			n_errors++;
			$display("MISMATCH %s: expected %0d, actual %0d", name, exp, act);
		end
	endtask

	task automatic check_idx(input string name, input logic [X_W-1:0] ex,
	                         input logic [Y_W-1:0] ey, input logic [X_W-1:0] ax,
	                         input logic [Y_W-1:0] ay);
		n_checks++;
		if (ax !== ex || ay !== ey) begin
			n_errors++;
			$display("MISMATCH %s: expected (%0d,%0d), actual (%0d,%0d)", name, ex, ey, ax, ay);
		end
	endtask

	task automatic report_test(input string name, input int err0);
		n_tests++;
		if (n_errors > err0) begin
			n_failed++;
			$display("test %s: fail, %0d errors", name, n_errors - err0);
		end else begin
			$display("test %s: ok", name);
		end
	endtask

	// intra frames use the intra stage, inter frames ime, fme and mc
	function automatic int expected_starts(input int s, input bit intra, input int n);
		if (s == enc_ctrl_pkg::ST_INTRA)
			return intra ? n : 0;
		if (s == enc_ctrl_pkg::ST_IME || s == enc_ctrl_pkg::ST_FME || s == enc_ctrl_pkg::ST_MC)
			return intra ? 0 : n;
		return n;
	endfunction

	// ********************
	// start monitor, index check and responder
	always @(negedge clk) begin
		if (frame_done)
			fd_cnt++;
		for (int s = 0; s < SN; s++) begin
			if (start_v[s]) begin
				// k-th start works on the k-th MB, x fastest
				check_idx({cur_test, " ", st_name[s], " index"},
				          X_W'(start_cnt[s] % (cur_xt + 1)),
				          Y_W'(start_cnt[s] / (cur_xt + 1)), mb_x[s], mb_y[s]);
				start_cnt[s]++;
				dly[s]  = 1 + $unsigned($random(seed)) % 6;
				busy[s] = 1'b1;
			end
		end
	end

	always @(posedge clk) begin
		for (int s = 0; s < SN; s++) begin
			stage_done[s] <= 1'b0;
			if (busy[s]) begin
				if (dly[s] <= 1) begin
					stage_done[s] <= 1'b1;  // one cycle done
					busy[s] = 1'b0;
				end else begin
					dly[s]--;
				end
			end
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > limit) begin
			$display("timeout: the frames did not finish within %0d cycles", limit);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	// ********************
	// one frame of the table
	task automatic run_frame(input int r);
		int n, err0, c, fs_at, fs_hits, ls_at, early;
		n       = (row_xt[r] + 1) * (row_yt[r] + 1);
		err0    = n_errors;
		fs_at   = 0;
		fs_hits = 0;
		ls_at   = 0;
		early   = 0;
		@(posedge clk);
		cur_test = row_name[r];
		cur_xt   = row_xt[r];
		fd_cnt   = 0;
		foreach (start_cnt[s])
			start_cnt[s] = 0;
		sys_intra <= row_intra[r];
		x_total   <= X_W'(row_xt[r]);
		y_total   <= Y_W'(row_yt[r]);
		bs_empty  <= 1'b0;
		sys_start <= 1'b1;
		@(posedge clk);  // start sampled here
		sys_start <= 1'b0;
		for (c = 1; c <= 5; c++) begin
			@(negedge clk);
			if (c == 1)
				check_bit({row_name[r], " sys_done cleared"}, 1'b0, sys_done);
			if (frame_start) begin
				fs_hits++;
				fs_at = c;
			end
			if (start_v[enc_ctrl_pkg::ST_LOAD] && ls_at == 0)
				ls_at = c;
		end
		check_count({row_name[r], " frame_start edge"}, 3, fs_at);
		check_count({row_name[r], " frame_start pulses"}, 1, fs_hits);
		check_count({row_name[r], " load_start edge"}, 4, ls_at);
		do begin
			@(negedge clk);
		end while (!frame_done);
		for (c = 0; c < row_bs[r]; c++) begin
			@(negedge clk);
			if (sys_done)
				early++;
		end
		check_count({row_name[r], " sys_done while bs busy"}, 0, early);
		@(posedge clk);
		bs_empty <= 1'b1;
		c = 0;
		do begin
			@(negedge clk);
			c++;
		end while (!sys_done);
		check_count({row_name[r], " sys_done delay"}, 3, c);  // idle, then done
		for (int s = 0; s < SN; s++)
			check_count({row_name[r], " ", st_name[s], " starts"},
			            expected_starts(s, row_intra[r], n), start_cnt[s]);
		check_count({row_name[r], " frame_done pulses"}, 1, fd_cnt);
		report_test(row_name[r], err0);
	endtask

	initial begin
		clk        = 1'b0;
		rst_n      = 1'b0;
		sys_start  = 1'b0;
		sys_intra  = 1'b0;
		bs_empty   = 1'b1;
		x_total    = '0;
		y_total    = '0;
		stage_done = '0;
		cur_test   = "reset";
		limit      = 0;
		for (int r = 0; r < ROWS; r++)
			limit += ((row_xt[r] + 1) * (row_yt[r] + 1) + 12) * 16;
		repeat (3) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		for (int s = 0; s < SN; s++)
			check_bit({"reset ", st_name[s], " start"}, 1'b0, start_v[s]);
		check_bit("reset frame_start", 1'b0, frame_start);
		check_bit("reset frame_done", 1'b0, frame_done);
		check_bit("reset sys_done", 1'b1, sys_done);
		report_test("reset", 0);
		for (int r = 0; r < ROWS; r++)
			run_frame(r);
		$display("tests %0d, failed %0d, checks %0d, errors %0d",
		         n_tests, n_failed, n_checks, n_errors);
		if (n_errors == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

/* src.f */
enc_geom_pkg.sv
enc_ctrl_pkg.sv
done_flag_bank.sv
pipe_fsm.sv
stage_start_gen.sv
mb_index_pipe.sv
enc_top_ctrl.sv
tb_enc_top_ctrl.sv

/* Bender.yml */
package:
  name: enc_top_ctrl

sources:
  - enc_geom_pkg.sv
  - enc_ctrl_pkg.sv
  - done_flag_bank.sv
  - pipe_fsm.sv
  - stage_start_gen.sv
  - mb_index_pipe.sv
  - enc_top_ctrl.sv
  - target: test
    files:
      - tb_enc_top_ctrl.sv
